// File: src/barrel_config.svh
`ifndef BARREL_CONFIG_SVH
`define BARREL_CONFIG_SVH

// ------------------------------
// Core sizing
// ------------------------------

// Hardware threads sharing the pipe, six or more
`define CORE_THREADS 8

// Word address widths of the two memories
`define IMEM_AW 10
`define DMEM_AW 10

// Thread t starts at t * stride (bytes)
`define PC_STRIDE 'h100

`endif

// File: src/rv_pkg.sv
`include "barrel_config.svh"

package rv_pkg;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [$clog2(`CORE_THREADS)-1:0] thread_t;
  typedef logic [`IMEM_AW-1:0] imem_addr_t;
  typedef logic [`DMEM_AW-1:0] dmem_addr_t;

  // ------------------------------
  // Decoded selects
  // ------------------------------

  // RV32I major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // ALU functions, PASS2 forwards operand 2 for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS2
  } alu_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

endpackage

// File: src/thread_fetch.sv
`timescale 1ns/1ps
`include "barrel_config.svh"

module thread_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_pc_we,
  input  rv_pkg::thread_t     i_pc_thread,
  input  rv_pkg::word_t       i_next_pc,
  output rv_pkg::imem_addr_t  o_imem_addr,
  output rv_pkg::thread_t     o_fetch_thread,
  output rv_pkg::word_t       o_fetch_pc,
  output logic                o_fetch_valid
);
  import rv_pkg::*;

  // One PC per thread
  word_t   pc_q [`CORE_THREADS];
  thread_t cnt_q;
  // Start flag, first fetch one cycle after reset drops
  logic    start_q;
  // Valid of the slot now in R and E
  logic    valid_r_q;
  logic    valid_e_q;

  // ------------------------------
  // Round-robin thread counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q       <= 1'b0;
      cnt_q         <= '0;
      o_fetch_valid <= 1'b0;
      valid_r_q     <= 1'b0;
      valid_e_q     <= 1'b0;
    end else begin
      start_q <= 1'b1;
      if (start_q) begin
        if (cnt_q == thread_t'(`CORE_THREADS - 1))
          cnt_q <= '0;
        else
          cnt_q <= cnt_q + thread_t'(1);
      end
      // Fetch valid follows the slot down to E
      o_fetch_valid <= start_q;
      valid_r_q     <= o_fetch_valid;
      valid_e_q     <= valid_r_q;
    end
  end

  // ------------------------------
  // PC file
  // ------------------------------

  // Start-up fill slots reaching E are ignored
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < `CORE_THREADS; t++)
        pc_q[t] <= word_t'(t * `PC_STRIDE);
    end else if (i_pc_we && valid_e_q) begin
      pc_q[i_pc_thread] <= i_next_pc;
    end
  end

  // Word address into the ROM
  assign o_imem_addr = pc_q[cnt_q][`IMEM_AW+1:2];

  // Thread and PC aligned with the ROM data
  always_ff @(posedge clk) begin
    o_fetch_thread <= cnt_q;
    o_fetch_pc     <= pc_q[cnt_q];
  end

endmodule

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::word_t      i_instr,
  input  rv_pkg::thread_t    i_thread,
  input  rv_pkg::word_t      i_pc,
  input  logic               i_valid,
  output rv_pkg::reg_addr_t  o_rs1,
  output rv_pkg::reg_addr_t  o_rs2,
  output rv_pkg::word_t      o_imm,
  output rv_pkg::alu_op_e    o_alu_op,
  output logic               o_op1_pc,
  output logic               o_op2_imm,
  output logic               o_branch,
  output logic               o_jump,
  output logic               o_jalr,
  output logic               o_mem_we,
  output logic               o_mem_re,
  output logic               o_rd_we,
  output logic [2:0]         o_funct3,
  output rv_pkg::wb_sel_e    o_wb_sel,
  output rv_pkg::reg_addr_t  o_rd,
  output rv_pkg::word_t      o_pc,
  output rv_pkg::thread_t    o_thread
);
  import rv_pkg::*;

  reg_addr_t  rd;
  logic [2:0] funct3;
  logic       alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm;
  alu_op_e    alu_op;
  alu_op_e    alu_fn;
  wb_sel_e    wb_sel;
  logic       op1_pc;
  logic       op2_imm;
  logic       branch;
  logic       jump;
  logic       jalr;
  logic       mem_we;
  logic       mem_re;
  logic       rd_we;

  // ------------------------------
  // Field split
  // ------------------------------
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt    = i_instr[30];

  // Sign-extended immediates per format
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  // ALU function from funct3, shared by OP and OP_IMM
  always_comb begin
    case (funct3)
      3'b000:  alu_fn = ALU_ADD;
      3'b001:  alu_fn = ALU_SLL;
      3'b010:  alu_fn = ALU_SLT;
      3'b011:  alu_fn = ALU_SLTU;
      3'b100:  alu_fn = ALU_XOR;
      3'b101:  alu_fn = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_fn = ALU_OR;
      default: alu_fn = ALU_AND;
    endcase
  end

  // ------------------------------
  // Control generation
  // ------------------------------
  always_comb begin
    imm     = imm_i;
    alu_op  = ALU_ADD;
    wb_sel  = WB_ALU;
    op1_pc  = 1'b0;
    op2_imm = 1'b1;
    branch  = 1'b0;
    jump    = 1'b0;
    jalr    = 1'b0;
    mem_we  = 1'b0;
    mem_re  = 1'b0;
    rd_we   = 1'b0;
    case (opcode_e'(i_instr[6:0]))
      OPC_OP: begin
        op2_imm = 1'b0;
        rd_we   = 1'b1;
        // Only register form has SUB
        alu_op  = (funct3 == 3'b000 && alt) ? ALU_SUB : alu_fn;
      end
      OPC_OP_IMM: begin
        rd_we  = 1'b1;
        alu_op = alu_fn;
      end
      OPC_LUI: begin
        imm    = imm_u;
        alu_op = ALU_PASS2;
        rd_we  = 1'b1;
      end
      OPC_AUIPC: begin
        imm    = imm_u;
        op1_pc = 1'b1;
        rd_we  = 1'b1;
      end
      // Target is PC + offset through the ALU adder
      OPC_BRANCH: begin
        imm    = imm_b;
        op1_pc = 1'b1;
        branch = 1'b1;
      end
      OPC_JAL: begin
        imm    = imm_j;
        op1_pc = 1'b1;
        jump   = 1'b1;
        rd_we  = 1'b1;
        wb_sel = WB_PC4;
      end
      OPC_JALR: begin
        jump   = 1'b1;
        jalr   = 1'b1;
        rd_we  = 1'b1;
        wb_sel = WB_PC4;
      end
      OPC_LOAD: begin
        mem_re = 1'b1;
        rd_we  = 1'b1;
        wb_sel = WB_MEM;
      end
      OPC_STORE: begin
        imm    = imm_s;
        mem_we = 1'b1;
      end
      // Unknown opcodes retire as a no-op
      default: begin
        op2_imm = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // D to R registers
  // ------------------------------

  // Enables killed for invalid slots and rd == x0
  always_ff @(posedge clk) begin
    if (reset) begin
      o_branch <= 1'b0;
      o_jump   <= 1'b0;
      o_mem_we <= 1'b0;
      o_mem_re <= 1'b0;
      o_rd_we  <= 1'b0;
    end else begin
      o_branch <= branch & i_valid;
      o_jump   <= jump & i_valid;
      o_mem_we <= mem_we & i_valid;
      o_mem_re <= mem_re & i_valid;
      o_rd_we  <= rd_we & i_valid & (rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    o_imm     <= imm;
    o_alu_op  <= alu_op;
    o_op1_pc  <= op1_pc;
    o_op2_imm <= op2_imm;
    o_jalr    <= jalr;
    o_funct3  <= funct3;
    o_wb_sel  <= wb_sel;
    o_rd      <= rd;
    o_pc      <= i_pc;
    o_thread  <= i_thread;
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "barrel_config.svh"

module reg_file (
  input  logic               clk,
  input  rv_pkg::thread_t    i_rd_thread,
  input  rv_pkg::reg_addr_t  i_rs1,
  input  rv_pkg::reg_addr_t  i_rs2,
  output rv_pkg::word_t      o_rdata1,
  output rv_pkg::word_t      o_rdata2,
  input  logic               i_we,
  input  rv_pkg::thread_t    i_wr_thread,
  input  rv_pkg::reg_addr_t  i_wr_addr,
  input  rv_pkg::word_t      i_wr_data
);
  import rv_pkg::*;

  localparam int RF_DEPTH = `CORE_THREADS * 32;

  // 32 words per thread, indexed {thread, reg}
  word_t regs [RF_DEPTH];
  word_t rdata1_q;
  word_t rdata2_q;
  // x0 reads, x0 itself is never written
  logic  zero1_q;
  logic  zero2_q;

  always_ff @(posedge clk) begin
    if (i_we)
      regs[{i_wr_thread, i_wr_addr}] <= i_wr_data;
  end

  // Registered read ports
  always_ff @(posedge clk) begin
    rdata1_q <= regs[{i_rd_thread, i_rs1}];
    rdata2_q <= regs[{i_rd_thread, i_rs2}];
    zero1_q  <= (i_rs1 == '0);
    zero2_q  <= (i_rs2 == '0);
  end

  assign o_rdata1 = zero1_q ? '0 : rdata1_q;
  assign o_rdata2 = zero2_q ? '0 : rdata2_q;

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::word_t      i_imm,
  input  rv_pkg::alu_op_e    i_alu_op,
  input  logic               i_op1_pc,
  input  logic               i_op2_imm,
  input  logic               i_branch,
  input  logic               i_jump,
  input  logic               i_jalr,
  input  logic               i_mem_we,
  input  logic               i_mem_re,
  input  logic               i_rd_we,
  input  logic [2:0]         i_funct3,
  input  rv_pkg::wb_sel_e    i_wb_sel,
  input  rv_pkg::reg_addr_t  i_rd,
  input  rv_pkg::word_t      i_pc,
  input  rv_pkg::thread_t    i_thread,
  input  rv_pkg::word_t      i_rdata1,
  input  rv_pkg::word_t      i_rdata2,
  output logic               o_pc_we,
  output rv_pkg::thread_t    o_pc_thread,
  output rv_pkg::word_t      o_next_pc,
  output rv_pkg::word_t      o_result,
  output rv_pkg::word_t      o_store_data,
  output logic               o_mem_we,
  output logic               o_mem_re,
  output logic               o_rd_we,
  output rv_pkg::wb_sel_e    o_wb_sel,
  output rv_pkg::reg_addr_t  o_rd,
  output rv_pkg::word_t      o_pc4,
  output rv_pkg::thread_t    o_thread
);
  import rv_pkg::*;

  // Slot copied from R into E
  word_t      e_imm;
  alu_op_e    e_alu_op;
  logic       e_op1_pc;
  logic       e_op2_imm;
  logic       e_branch;
  logic       e_jump;
  logic       e_jalr;
  logic       e_mem_we;
  logic       e_mem_re;
  logic       e_rd_we;
  logic [2:0] e_funct3;
  wb_sel_e    e_wb_sel;
  reg_addr_t  e_rd;
  word_t      e_pc;
  thread_t    e_thread;
  word_t      e_rdata1;
  word_t      e_rdata2;

  word_t op1;
  word_t op2;
  word_t alu_res;
  word_t pc4;
  word_t target;
  logic  br_cond;
  logic  taken;

  // ------------------------------
  // R to E registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      e_branch <= 1'b0;
      e_jump   <= 1'b0;
      e_mem_we <= 1'b0;
      e_mem_re <= 1'b0;
      e_rd_we  <= 1'b0;
    end else begin
      e_branch <= i_branch;
      e_jump   <= i_jump;
      e_mem_we <= i_mem_we;
      e_mem_re <= i_mem_re;
      e_rd_we  <= i_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    e_imm     <= i_imm;
    e_alu_op  <= i_alu_op;
    e_op1_pc  <= i_op1_pc;
    e_op2_imm <= i_op2_imm;
    e_jalr    <= i_jalr;
    e_funct3  <= i_funct3;
    e_wb_sel  <= i_wb_sel;
    e_rd      <= i_rd;
    e_pc      <= i_pc;
    e_thread  <= i_thread;
    e_rdata1  <= i_rdata1;
    e_rdata2  <= i_rdata2;
  end

  // ------------------------------
  // Operands and ALU
  // ------------------------------
  assign op1 = e_op1_pc ? e_pc : e_rdata1;
  assign op2 = e_op2_imm ? e_imm : e_rdata2;

  always_comb begin
    case (e_alu_op)
      ALU_SUB:   alu_res = op1 - op2;
      ALU_AND:   alu_res = op1 & op2;
      ALU_OR:    alu_res = op1 | op2;
      ALU_XOR:   alu_res = op1 ^ op2;
      ALU_SLT:   alu_res = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU:  alu_res = {31'b0, op1 < op2};
      ALU_SLL:   alu_res = op1 << op2[4:0];
      ALU_SRL:   alu_res = op1 >> op2[4:0];
      ALU_SRA:   alu_res = word_t'($signed(op1) >>> op2[4:0]);
      ALU_PASS2: alu_res = op2;
      default:   alu_res = op1 + op2;
    endcase
  end

  // Branch condition on the two register operands
  always_comb begin
    case (e_funct3)
      3'b000:  br_cond = (e_rdata1 == e_rdata2);
      3'b001:  br_cond = (e_rdata1 != e_rdata2);
      3'b100:  br_cond = $signed(e_rdata1) < $signed(e_rdata2);
      3'b101:  br_cond = $signed(e_rdata1) >= $signed(e_rdata2);
      3'b110:  br_cond = e_rdata1 < e_rdata2;
      3'b111:  br_cond = e_rdata1 >= e_rdata2;
      default: br_cond = 1'b0;
    endcase
  end

  // ------------------------------
  // Next PC
  // ------------------------------
  assign pc4    = e_pc + 32'd4;
  // JALR clears bit 0 of the sum
  assign target = {alu_res[31:1], alu_res[0] & ~e_jalr};
  assign taken  = e_jump | (e_branch & br_cond);

  // Each slot in E rewrites its own thread's PC
  assign o_pc_we     = 1'b1;
  assign o_pc_thread = e_thread;
  assign o_next_pc   = taken ? target : pc4;

  // ------------------------------
  // E to M registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      o_mem_we <= 1'b0;
      o_mem_re <= 1'b0;
      o_rd_we  <= 1'b0;
    end else begin
      o_mem_we <= e_mem_we;
      o_mem_re <= e_mem_re;
      o_rd_we  <= e_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    o_result     <= alu_res;
    o_store_data <= e_rdata2;
    o_wb_sel     <= e_wb_sel;
    o_rd         <= e_rd;
    o_pc4        <= pc4;
    o_thread     <= e_thread;
  end

endmodule

// File: src/lsu_writeback.sv
`timescale 1ns/1ps
`include "barrel_config.svh"

module lsu_writeback (
  input  logic                clk,
  input  logic                reset,
  input  rv_pkg::word_t       i_result,
  input  rv_pkg::word_t       i_store_data,
  input  logic                i_mem_we,
  input  logic                i_mem_re,
  input  logic                i_rd_we,
  input  rv_pkg::wb_sel_e     i_wb_sel,
  input  rv_pkg::reg_addr_t   i_rd,
  input  rv_pkg::word_t       i_pc4,
  input  rv_pkg::thread_t     i_thread,
  input  rv_pkg::word_t       i_dmem_rdata,
  output rv_pkg::dmem_addr_t  o_dmem_addr,
  output rv_pkg::word_t       o_dmem_wdata,
  output logic                o_dmem_we,
  output logic                o_dmem_re,
  output rv_pkg::thread_t     o_dmem_thread,
  output logic                o_wb_en,
  output rv_pkg::thread_t     o_wb_thread,
  output rv_pkg::reg_addr_t   o_wb_addr,
  output rv_pkg::word_t       o_wb_data
);
  import rv_pkg::*;

  wb_sel_e sel_q;
  word_t   result_q;
  word_t   pc4_q;

  // ------------------------------
  // Data memory, word access only
  // ------------------------------
  assign o_dmem_addr   = i_result[`DMEM_AW+1:2];
  assign o_dmem_wdata  = i_store_data;
  assign o_dmem_we     = i_mem_we;
  assign o_dmem_re     = i_mem_re;
  assign o_dmem_thread = i_thread;

  // M to W, lines up with the memory read data
  always_ff @(posedge clk) begin
    if (reset)
      o_wb_en <= 1'b0;
    else
      o_wb_en <= i_rd_we;
  end

  always_ff @(posedge clk) begin
    o_wb_thread <= i_thread;
    o_wb_addr   <= i_rd;
    sel_q       <= i_wb_sel;
    result_q    <= i_result;
    pc4_q       <= i_pc4;
  end

  // Writeback source select
  always_comb begin
    case (sel_q)
      WB_MEM:  o_wb_data = i_dmem_rdata;
      WB_PC4:  o_wb_data = pc4_q;
      default: o_wb_data = result_q;
    endcase
  end

endmodule

// File: src/barrel_core.sv
`timescale 1ns/1ps

module barrel_core (
  input  logic                clk,
  input  logic                reset,
  input  rv_pkg::word_t       i_imem_data,
  input  rv_pkg::word_t       i_dmem_rdata,
  output rv_pkg::imem_addr_t  o_imem_addr,
  output rv_pkg::dmem_addr_t  o_dmem_addr,
  output rv_pkg::word_t       o_dmem_wdata,
  output logic                o_dmem_we,
  output logic                o_dmem_re,
  output rv_pkg::thread_t     o_dmem_thread,
  output logic                o_wb_en,
  output rv_pkg::thread_t     o_wb_thread,
  output rv_pkg::reg_addr_t   o_wb_addr,
  output rv_pkg::word_t       o_wb_data
);
  import rv_pkg::*;

  // ------------------------------
  // Stage wires
  // ------------------------------

  // PC update from E
  logic      pc_we;
  thread_t   pc_thread;
  word_t     next_pc;
  // F to D
  thread_t   f_thread;
  word_t     f_pc;
  logic      f_valid;
  // D to register file
  reg_addr_t rs1;
  reg_addr_t rs2;
  // R stage
  word_t     r_imm;
  alu_op_e   r_alu_op;
  logic      r_op1_pc;
  logic      r_op2_imm;
  logic      r_branch;
  logic      r_jump;
  logic      r_jalr;
  logic      r_mem_we;
  logic      r_mem_re;
  logic      r_rd_we;
  logic [2:0] r_funct3;
  wb_sel_e   r_wb_sel;
  reg_addr_t r_rd;
  word_t     r_pc;
  thread_t   r_thread;
  word_t     rdata1;
  word_t     rdata2;
  // M stage
  word_t     m_result;
  word_t     m_store_data;
  logic      m_mem_we;
  logic      m_mem_re;
  logic      m_rd_we;
  wb_sel_e   m_wb_sel;
  reg_addr_t m_rd;
  word_t     m_pc4;
  thread_t   m_thread;

  thread_fetch i_thread_fetch (
    .clk            (clk),
    .reset          (reset),
    .i_pc_we        (pc_we),
    .i_pc_thread    (pc_thread),
    .i_next_pc      (next_pc),
    .o_imem_addr    (o_imem_addr),
    .o_fetch_thread (f_thread),
    .o_fetch_pc     (f_pc),
    .o_fetch_valid  (f_valid)
  );

  decode_unit i_decode_unit (
    .clk       (clk),
    .reset     (reset),
    .i_instr   (i_imem_data),
    .i_thread  (f_thread),
    .i_pc      (f_pc),
    .i_valid   (f_valid),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_imm     (r_imm),
    .o_alu_op  (r_alu_op),
    .o_op1_pc  (r_op1_pc),
    .o_op2_imm (r_op2_imm),
    .o_branch  (r_branch),
    .o_jump    (r_jump),
    .o_jalr    (r_jalr),
    .o_mem_we  (r_mem_we),
    .o_mem_re  (r_mem_re),
    .o_rd_we   (r_rd_we),
    .o_funct3  (r_funct3),
    .o_wb_sel  (r_wb_sel),
    .o_rd      (r_rd),
    .o_pc      (r_pc),
    .o_thread  (r_thread)
  );

  // Read in D for the thread being decoded, write from W
  reg_file i_reg_file (
    .clk         (clk),
    .i_rd_thread (f_thread),
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .o_rdata1    (rdata1),
    .o_rdata2    (rdata2),
    .i_we        (o_wb_en),
    .i_wr_thread (o_wb_thread),
    .i_wr_addr   (o_wb_addr),
    .i_wr_data   (o_wb_data)
  );

  execute_unit i_execute_unit (
    .clk          (clk),
    .reset        (reset),
    .i_imm        (r_imm),
    .i_alu_op     (r_alu_op),
    .i_op1_pc     (r_op1_pc),
    .i_op2_imm    (r_op2_imm),
    .i_branch     (r_branch),
    .i_jump       (r_jump),
    .i_jalr       (r_jalr),
    .i_mem_we     (r_mem_we),
    .i_mem_re     (r_mem_re),
    .i_rd_we      (r_rd_we),
    .i_funct3     (r_funct3),
    .i_wb_sel     (r_wb_sel),
    .i_rd         (r_rd),
    .i_pc         (r_pc),
    .i_thread     (r_thread),
    .i_rdata1     (rdata1),
    .i_rdata2     (rdata2),
    .o_pc_we      (pc_we),
    .o_pc_thread  (pc_thread),
    .o_next_pc    (next_pc),
    .o_result     (m_result),
    .o_store_data (m_store_data),
    .o_mem_we     (m_mem_we),
    .o_mem_re     (m_mem_re),
    .o_rd_we      (m_rd_we),
    .o_wb_sel     (m_wb_sel),
    .o_rd         (m_rd),
    .o_pc4        (m_pc4),
    .o_thread     (m_thread)
  );

  lsu_writeback i_lsu_writeback (
    .clk           (clk),
    .reset         (reset),
    .i_result      (m_result),
    .i_store_data  (m_store_data),
    .i_mem_we      (m_mem_we),
    .i_mem_re      (m_mem_re),
    .i_rd_we       (m_rd_we),
    .i_wb_sel      (m_wb_sel),
    .i_rd          (m_rd),
    .i_pc4         (m_pc4),
    .i_thread      (m_thread),
    .i_dmem_rdata  (i_dmem_rdata),
    .o_dmem_addr   (o_dmem_addr),
    .o_dmem_wdata  (o_dmem_wdata),
    .o_dmem_we     (o_dmem_we),
    .o_dmem_re     (o_dmem_re),
    .o_dmem_thread (o_dmem_thread),
    .o_wb_en       (o_wb_en),
    .o_wb_thread   (o_wb_thread),
    .o_wb_addr     (o_wb_addr),
    .o_wb_data     (o_wb_data)
  );

endmodule

// File: verification/tb_barrel_core.sv
`timescale 1ns/1ps
`include "barrel_config.svh"

module tb_barrel_core;
  import rv_pkg::*;

  localparam int SEED      = 35869;
  localparam int ROM_WORDS = 1 << `IMEM_AW;
  localparam int RAM_WORDS = 1 << `DMEM_AW;
  localparam int TW        = $clog2(`CORE_THREADS);
  // Earliest M and W cycles of the first fetch, counted from reset release
  localparam int MEM_QUIET = 5;
  localparam int WB_QUIET  = 6;

  logic       clk;
  logic       reset;
  word_t      imem_data;
  word_t      dmem_rdata;
  imem_addr_t imem_addr;
  dmem_addr_t dmem_addr;
  word_t      dmem_wdata;
  logic       dmem_we;
  logic       dmem_re;
  thread_t    dmem_thread;
  logic       wb_en;
  thread_t    wb_thread;
  reg_addr_t  wb_addr;
  word_t      wb_data;

  word_t rom [ROM_WORDS];
  word_t ram [RAM_WORDS];
  // Expected writebacks {thread, rd, data}
  logic [TW+36:0] wb_q [$];
  // Expected stores {thread, word address, data}
  logic [TW+`DMEM_AW+31:0] st_q [$];
  int limit;
  int cycles = 0;
  int post_reset = 0;
  // Writeback seen one cycle earlier
  logic    prev_wb_en = 1'b0;
  thread_t prev_wb_thread;

  barrel_core i_barrel_core (
    .clk           (clk),
    .reset         (reset),
    .i_imem_data   (imem_data),
    .i_dmem_rdata  (dmem_rdata),
    .o_imem_addr   (imem_addr),
    .o_dmem_addr   (dmem_addr),
    .o_dmem_wdata  (dmem_wdata),
    .o_dmem_we     (dmem_we),
    .o_dmem_re     (dmem_re),
    .o_dmem_thread (dmem_thread),
    .o_wb_en       (wb_en),
    .o_wb_thread   (wb_thread),
    .o_wb_addr     (wb_addr),
    .o_wb_data     (wb_data)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // Round-robin successor of a thread
  function automatic thread_t next_thread(input thread_t t);
    return thread_t'((int'(t) + 1) % `CORE_THREADS);
  endfunction

  // ------------------------------
  // Cases file
  // ------------------------------
  task automatic load_cases();
    int fd;
    int n;
    int most;
    string line;
    string rest;
    byte tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int count [`CORE_THREADS];
    most = 0;
    foreach (count[t])
      count[t] = 0;
    fd = $fopen("verification/core_cases.txt", "r");
    if (fd == 0)
      report_fail("cannot open verification/core_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#")
        continue;
      tag  = line[0];
      rest = line.substr(1, line.len() - 1);
      n = $sscanf(rest, "%h %h %h", a, b, c);
      case (tag)
        // Byte address into the ROM
        "I": rom[a[`IMEM_AW+1:2]] = b;
        // Word address into the RAM
        "D": ram[a[`DMEM_AW-1:0]] = b;
        "W": begin
          wb_q.push_back({thread_t'(a), reg_addr_t'(b), c});
          count[a]++;
        end
        "S": begin
          st_q.push_back({thread_t'(a), dmem_addr_t'(b), c});
          count[a]++;
        end
        default: report_fail($sformatf("unknown line in the cases file: %s", line));
      endcase
    end
    $fclose(fd);
    foreach (count[t])
      if (count[t] > most)
        most = count[t];
    limit = (most + 8) * `CORE_THREADS * 6 + 20;
  endtask

  // ------------------------------
  // Clock, reset, memories
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset      = 1'b1;
    imem_data  = '0;
    dmem_rdata = '0;
    void'($urandom(SEED));
    // Unused ROM words hold addi x0, x0, addr
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = {i[11:0], 20'h00013};
    for (int i = 0; i < RAM_WORDS; i++)
      ram[i] = $urandom;
    load_cases();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

  // Both memories answer one cycle after the address
  always @(posedge clk) begin
    imem_data <= rom[imem_addr];
    if (dmem_we)
      ram[dmem_addr] <= dmem_wdata;
    // Stored word only returned for a requested read
    if (dmem_re)
      dmem_rdata <= ram[dmem_addr];
    else
      dmem_rdata <= $urandom;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic check_writeback();
    int idx;
    reg_addr_t rd;
    word_t val;
    idx = -1;
    // Oldest pending entry of this thread
    foreach (wb_q[i])
      if (idx < 0 && wb_q[i][TW+36:37] == wb_thread)
        idx = i;
    assert (idx >= 0)
    else report_fail($sformatf("unexpected writeback from thread %0d to x%0d",
                               wb_thread, wb_addr));
    rd  = wb_q[idx][36:32];
    val = wb_q[idx][31:0];
    assert (wb_addr == rd)
    else report_fail($sformatf("FAIL o_wb_addr: got %h, expected %h", wb_addr, rd));
    assert (wb_data == val)
    else report_fail($sformatf("FAIL o_wb_data: got %h, expected %h", wb_data, val));
    wb_q.delete(idx);
  endtask

  task automatic check_store();
    int idx;
    dmem_addr_t addr;
    word_t val;
    idx = -1;
    foreach (st_q[i])
      if (idx < 0 && st_q[i][TW+`DMEM_AW+31:`DMEM_AW+32] == dmem_thread)
        idx = i;
    assert (idx >= 0)
    else report_fail($sformatf("unexpected store from thread %0d", dmem_thread));
    addr = st_q[idx][`DMEM_AW+31:32];
    val  = st_q[idx][31:0];
    assert (dmem_addr == addr)
    else report_fail($sformatf("FAIL o_dmem_addr: got %h, expected %h", dmem_addr, addr));
    assert (dmem_wdata == val)
    else report_fail($sformatf("FAIL o_dmem_wdata: got %h, expected %h", dmem_wdata, val));
    st_q.delete(idx);
  endtask

  // Outputs settle after the rising edge
  always @(negedge clk) begin
    if (reset || post_reset < MEM_QUIET) begin
      assert (!dmem_we && !dmem_re)
      else report_fail("a memory enable went high during reset or start-up");
    end
    if (reset || post_reset < WB_QUIET) begin
      assert (!wb_en)
      else report_fail("a writeback came out earlier than the pipeline latency allows");
    end
    // Back-to-back writebacks come from neighboring threads
    if (wb_en && prev_wb_en) begin
      assert (wb_thread == next_thread(prev_wb_thread))
      else report_fail($sformatf("FAIL o_wb_thread: got %h, expected %h",
                                 wb_thread, next_thread(prev_wb_thread)));
    end
    prev_wb_en     = wb_en;
    prev_wb_thread = wb_thread;
    if (wb_en)
      check_writeback();
    if (dmem_we)
      check_store();
  end

  // Completion and timeout
  always @(posedge clk) begin
    if (reset) begin
      post_reset <= 0;
    end else begin
      post_reset <= post_reset + 1;
      cycles     <= cycles + 1;
      if (cycles > limit) begin
        report_fail($sformatf("timeout after %0d cycles, expected events still missing",
                              cycles));
      end else if (wb_q.size() == 0 && st_q.size() == 0) begin
        $display("Test OK");
        $finish;
      end
    end
  end

endmodule

// File: vlog.f
+incdir+src
src/rv_pkg.sv
src/thread_fetch.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/lsu_writeback.sv
src/barrel_core.sv
verification/tb_barrel_core.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_barrel_core: vlog.f src/*.sv src/*.svh verification/*.sv
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_barrel_core

run: obj_dir/Vtb_barrel_core
	-./obj_dir/Vtb_barrel_core > sim.log 2>&1
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module barrel_core

clean:
	rm -rf obj_dir sim.log

// File: verification/core_cases.txt
# I byteaddr instr | D wordaddr data | W thread rd value | S thread wordaddr data
# Thread t starts at byte t*100, every program ends in jal x0, 0
I 000 00500093
I 004 ffd00113
I 008 002081b3
I 00c 40208233
I 010 001122b3
I 014 00113333
I 018 401153b3
I 01c 01c15413
I 020 0ff0c493
I 024 12345537
I 028 00708013
I 02c 001005b3
I 030 0000006f
W 0 01 00000005
W 0 02 fffffffd
W 0 03 00000002
W 0 04 00000008
W 0 05 00000001
W 0 06 00000000
W 0 07 ffffffff
W 0 08 0000000f
W 0 09 000000fa
W 0 0a 12345000
W 0 0b 00000005
# Thread 1 branches and jumps
I 100 00100093
I 104 00009463
I 108 00900113
I 10c 008001ef
I 110 00100213
I 114 12500293
I 118 00028367
I 11c 00100393
I 124 00008463
I 128 00001417
I 12c 0000006f
W 1 01 00000001
W 1 03 00000110
W 1 05 00000125
W 1 06 0000011c
W 1 08 00001128
# Thread 2 loads and stores
D 040 cafef00d
I 200 10002083
I 204 7ab00113
I 208 10202223
I 20c 10102423
I 210 10402183
I 214 0000006f
W 2 01 cafef00d
W 2 02 000007ab
S 2 041 000007ab
S 2 042 cafef00d
W 2 03 000007ab
# Threads 3 to 7 idle
I 300 0000006f
I 400 0000006f
I 500 0000006f
I 600 0000006f
I 700 0000006f
